// File: logic/median_settings.svh
/* pixel, address, dimension and host widths plus sort latency */
`ifndef MEDIAN_SETTINGS_SVH
`define MEDIAN_SETTINGS_SVH

// one greyscale pixel
`define PIX_W 8

// 256 pixels per memory
`define ADDR_W 8

// frame width and height up to 16
`define DIM_W 5

// host bus word
`define HOST_W 32

// depth of the median network
`define SORT_LAT 3

`endif

// File: logic/median_pkg.sv
/* vector typedefs plus register select and engine state enums */
`include "median_settings.svh"

package median_pkg;

    typedef logic [`PIX_W-1:0] pixel_t;
    typedef logic [`ADDR_W-1:0] ram_addr_t;
    typedef logic [`DIM_W-1:0] dim_t;
    typedef logic [`HOST_W-1:0] host_data_t;

    // two select bits above the pixel address
    typedef logic [`ADDR_W+1:0] host_addr_t;

    // position 0 is the top-left neighbour in the low bits
    typedef logic [9*`PIX_W-1:0] window_t;

    typedef enum logic [1:0] {
        SEL_PIXEL  = 2'd0,
        SEL_CTRL   = 2'd1,
        SEL_WIDTH  = 2'd2,
        SEL_HEIGHT = 2'd3
    } reg_sel_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } engine_state_t;

endpackage

// File: logic/frame_ram.sv
/* single-port synchronous pixel memory */
`timescale 1ns/1ns
`include "median_settings.svh"

module frame_ram (
    input  logic               CLK,
    input  logic               en_i,
    input  logic               we_i,
    input  logic [`ADDR_W-1:0] addr_i,
    input  logic [`PIX_W-1:0]  wdata_i,
    output logic [`PIX_W-1:0]  rdata_o
);
    logic [`PIX_W-1:0] mem [2**`ADDR_W];

    // read data holds until the next read
    always_ff @(posedge CLK) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// File: logic/median_regs.sv
/* host register block with start, width and height registers,
   pixel select decode toward the memories and registered readback */
`timescale 1ns/1ns
`include "median_settings.svh"

module median_regs
    import median_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       ena_i,
    input  logic       wea_i,
    input  host_addr_t addr_i,
    input  host_data_t data_i,
    input  logic       done_i,
    input  pixel_t     res_rdata_i,
    output host_data_t data_o,
    output logic       start_o,
    output dim_t       width_o,
    output dim_t       height_o,
    output logic       host_we_o,
    output logic       host_re_o,
    output ram_addr_t  host_addr_o,
    output pixel_t     host_wdata_o
);
    reg_sel_t   sel;
    reg_sel_t   rd_sel_q;
    logic       start_q;
    dim_t       width_q;
    dim_t       height_q;
    logic       rd_done_q;
    host_data_t rd_reg_q;
    host_data_t reg_mux;

    assign sel = reg_sel_t'(addr_i[`ADDR_W +: 2]);

    // pixel accesses go on to the arbiter
    assign host_we_o    = ena_i && wea_i && (sel == SEL_PIXEL);
    assign host_re_o    = ena_i && !wea_i && (sel == SEL_PIXEL);
    assign host_addr_o  = addr_i[`ADDR_W-1:0];
    assign host_wdata_o = data_i[`PIX_W-1:0];

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            start_q  <= 1'b0;
            width_q  <= '0;
            height_q <= '0;
        end
        else if (ena_i && wea_i) begin
            case (sel)
                SEL_CTRL:   start_q  <= data_i[0];
                SEL_WIDTH:  width_q  <= data_i[`DIM_W-1:0];
                SEL_HEIGHT: height_q <= data_i[`DIM_W-1:0];
                default:    ;
            endcase
        end
    end

    always_comb begin
        case (sel)
            SEL_CTRL:   reg_mux = host_data_t'(done_i);
            SEL_WIDTH:  reg_mux = host_data_t'(width_q);
            SEL_HEIGHT: reg_mux = host_data_t'(height_q);
            default:    reg_mux = '0;
        endcase
    end

    // remember what the last read asked for
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            rd_sel_q  <= SEL_PIXEL;
            rd_done_q <= 1'b0;
            rd_reg_q  <= '0;
        end
        else if (ena_i && !wea_i) begin
            rd_sel_q  <= sel;
            rd_done_q <= done_i;
            rd_reg_q  <= reg_mux;
        end
    end

    // result pixels only visible once the frame is done
    assign data_o = (rd_sel_q == SEL_PIXEL) ?
                    (rd_done_q ? host_data_t'(res_rdata_i) : '0) : rd_reg_q;

    assign start_o  = start_q;
    assign width_o  = width_q;
    assign height_o = height_q;

endmodule

// File: logic/ram_arbiter.sv
/* memory arbiter granting source and result memories to host or engine */
`timescale 1ns/1ns

module ram_arbiter
    import median_pkg::*;
(
    input  logic      busy_i,
    input  logic      host_we_i,
    input  logic      host_re_i,
    input  ram_addr_t host_addr_i,
    input  pixel_t    host_wdata_i,
    input  logic      eng_src_re_i,
    input  logic      eng_res_we_i,
    input  ram_addr_t eng_addr_i,
    input  pixel_t    eng_wdata_i,
    output logic      src_en_o,
    output logic      src_we_o,
    output ram_addr_t src_addr_o,
    output pixel_t    src_wdata_o,
    output logic      res_en_o,
    output logic      res_we_o,
    output ram_addr_t res_addr_o,
    output pixel_t    res_wdata_o
);
    // source memory takes host writes and engine reads
    assign src_en_o    = busy_i ? eng_src_re_i : host_we_i;
    assign src_we_o    = !busy_i && host_we_i;
    assign src_addr_o  = busy_i ? eng_addr_i : host_addr_i;
    assign src_wdata_o = host_wdata_i;

    // result memory takes engine writes and host reads
    assign res_en_o    = busy_i ? eng_res_we_i : host_re_i;
    assign res_we_o    = busy_i && eng_res_we_i;
    assign res_addr_o  = busy_i ? eng_addr_i : host_addr_i;
    assign res_wdata_o = eng_wdata_i;

endmodule

// File: logic/filter_engine.sv
/* filter engine with control FSM, sweep counters, neighbour addressing,
   zero border and window assembly */
`timescale 1ns/1ns
`include "median_settings.svh"

module filter_engine
    import median_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  logic      start_i,
    input  dim_t      width_i,
    input  dim_t      height_i,
    input  pixel_t    src_rdata_i,
    input  pixel_t    median_i,
    input  logic      median_valid_i,
    output logic      busy_o,
    output logic      done_o,
    output logic      eng_src_re_o,
    output logic      eng_res_we_o,
    output ram_addr_t eng_addr_o,
    output pixel_t    eng_wdata_o,
    output window_t   window_o,
    output logic      win_valid_o
);
    // positions past the nine reads
    localparam logic [3:0] POS_CAP  = 4'd9;
    localparam logic [3:0] POS_WAIT = 4'd10;

    engine_state_t state_q;
    dim_t          row_q;
    dim_t          col_q;
    dim_t          last_row;
    dim_t          last_col;
    ram_addr_t     row_base_q;
    ram_addr_t     row_off;
    ram_addr_t     col_off;
    ram_addr_t     rd_addr;
    logic [3:0]    pos_q;
    logic [3:0]    pos_d_q;
    logic [1:0]    rd_dy;
    logic [1:0]    rd_dx;
    logic [1:0]    cap_dy;
    logic [1:0]    cap_dx;
    logic          cap_q;
    logic          win_valid_q;
    logic          last_pixel;
    logic          off_frame;
    window_t       window_q;

    assign last_row   = height_i - dim_t'(1);
    assign last_col   = width_i - dim_t'(1);
    assign last_pixel = (row_q == last_row) && (col_q == last_col);

    assign busy_o = (state_q == ST_RUN);
    assign done_o = (state_q == ST_DONE);

    // neighbour row and column inside the 3x3 window
    assign rd_dy  = 2'(pos_q / 4'd3);
    assign rd_dx  = 2'(pos_q % 4'd3);
    assign cap_dy = 2'(pos_d_q / 4'd3);
    assign cap_dx = 2'(pos_d_q % 4'd3);

    always_comb begin
        case (rd_dy)
            2'd0:    row_off = ram_addr_t'(0) - ram_addr_t'(width_i);
            2'd2:    row_off = ram_addr_t'(width_i);
            default: row_off = '0;
        endcase
        case (rd_dx)
            2'd0:    col_off = '1;
            2'd2:    col_off = ram_addr_t'(1);
            default: col_off = '0;
        endcase
    end

    // wrapped addresses are harmless since the border is zeroed
    assign rd_addr = row_base_q + ram_addr_t'(col_q) + row_off + col_off;

    assign eng_src_re_o = busy_o && (pos_q < POS_CAP);
    assign eng_res_we_o = busy_o && median_valid_i;
    assign eng_addr_o   = eng_res_we_o ? row_base_q + ram_addr_t'(col_q) : rd_addr;
    assign eng_wdata_o  = median_i;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q    <= ST_IDLE;
            row_q      <= '0;
            col_q      <= '0;
            row_base_q <= '0;
            pos_q      <= '0;
        end
        else begin
            case (state_q)
                ST_IDLE: begin
                    row_q      <= '0;
                    col_q      <= '0;
                    row_base_q <= '0;
                    pos_q      <= '0;
                    if (start_i) begin
                        state_q <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (median_valid_i) begin
                        pos_q <= '0;
                        if (last_pixel) begin
                            state_q <= ST_DONE;
                        end
                        else if (col_q == last_col) begin
                            col_q      <= '0;
                            row_q      <= row_q + dim_t'(1);
                            row_base_q <= row_base_q + ram_addr_t'(width_i);
                        end
                        else begin
                            col_q <= col_q + dim_t'(1);
                        end
                    end
                    else if (pos_q != POS_WAIT) begin
                        pos_q <= pos_q + 4'd1;
                    end
                end
                ST_DONE: begin
                    if (!start_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // read data arrives one cycle after the request
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            cap_q       <= 1'b0;
            pos_d_q     <= '0;
            win_valid_q <= 1'b0;
        end
        else begin
            cap_q       <= eng_src_re_o;
            pos_d_q     <= pos_q;
            win_valid_q <= busy_o && (pos_q == POS_CAP);
        end
    end

    // neighbours outside the frame read as zero
    assign off_frame = ((cap_dy == 2'd0) && (row_q == '0)) ||
                       ((cap_dy == 2'd2) && (row_q == last_row)) ||
                       ((cap_dx == 2'd0) && (col_q == '0)) ||
                       ((cap_dx == 2'd2) && (col_q == last_col));

    always_ff @(posedge CLK) begin
        if (cap_q) begin
            window_q[pos_d_q*`PIX_W +: `PIX_W] <= off_frame ? '0 : src_rdata_i;
        end
    end

    assign window_o    = window_q;
    assign win_valid_o = win_valid_q;

endmodule

// File: logic/median_sort.sv
/* three-stage pipelined median-of-nine compare network */
`timescale 1ns/1ns
`include "median_settings.svh"

module median_sort
    import median_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  window_t window_i,
    input  logic    valid_i,
    output pixel_t  median_o,
    output logic    valid_o
);
    pixel_t                lo_q [3];
    pixel_t                mid_q [3];
    pixel_t                hi_q [3];
    pixel_t                s2_lo_q;
    pixel_t                s2_mid_q;
    pixel_t                s2_hi_q;
    pixel_t                median_q;
    logic [`SORT_LAT-1:0]  vld_q;

    function automatic pixel_t min2(input pixel_t a, input pixel_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic pixel_t max2(input pixel_t a, input pixel_t b);
        return (a < b) ? b : a;
    endfunction

    function automatic pixel_t med3(input pixel_t a, input pixel_t b, input pixel_t c);
        return max2(min2(a, b), min2(max2(a, b), c));
    endfunction

    // stage one sorts each window row
    always_ff @(posedge CLK) begin
        for (int r = 0; r < 3; r++) begin
            lo_q[r]  <= min2(min2(window_i[(3*r)*`PIX_W +: `PIX_W],
                                  window_i[(3*r+1)*`PIX_W +: `PIX_W]),
                             window_i[(3*r+2)*`PIX_W +: `PIX_W]);
            mid_q[r] <= med3(window_i[(3*r)*`PIX_W +: `PIX_W],
                             window_i[(3*r+1)*`PIX_W +: `PIX_W],
                             window_i[(3*r+2)*`PIX_W +: `PIX_W]);
            hi_q[r]  <= max2(max2(window_i[(3*r)*`PIX_W +: `PIX_W],
                                  window_i[(3*r+1)*`PIX_W +: `PIX_W]),
                             window_i[(3*r+2)*`PIX_W +: `PIX_W]);
        end
    end

    // stage two works down the columns
    always_ff @(posedge CLK) begin
        s2_lo_q  <= max2(max2(lo_q[0], lo_q[1]), lo_q[2]);
        s2_mid_q <= med3(mid_q[0], mid_q[1], mid_q[2]);
        s2_hi_q  <= min2(min2(hi_q[0], hi_q[1]), hi_q[2]);
    end

    // stage three picks the diagonal median
    always_ff @(posedge CLK) begin
        median_q <= med3(s2_lo_q, s2_mid_q, s2_hi_q);
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            vld_q <= '0;
        end
        else begin
            vld_q <= {vld_q[`SORT_LAT-2:0], valid_i};
        end
    end

    assign median_o = median_q;
    assign valid_o  = vld_q[`SORT_LAT-1];

endmodule

// File: logic/median_filter_top.sv
/* median filter top with register block, arbiter, two frame memories,
   filter engine and median network */
`timescale 1ns/1ns

module median_filter_top
    import median_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       ena_i,
    input  logic       wea_i,
    input  host_addr_t addr_i,
    input  host_data_t data_i,
    output host_data_t data_o
);
    logic      start;
    dim_t      width;
    dim_t      height;
    logic      busy;
    logic      done;
    logic      host_we;
    logic      host_re;
    ram_addr_t host_addr;
    pixel_t    host_wdata;
    logic      eng_src_re;
    logic      eng_res_we;
    ram_addr_t eng_addr;
    pixel_t    eng_wdata;
    logic      src_en;
    logic      src_we;
    ram_addr_t src_addr;
    pixel_t    src_wdata;
    pixel_t    src_rdata;
    logic      res_en;
    logic      res_we;
    ram_addr_t res_addr;
    pixel_t    res_wdata;
    pixel_t    res_rdata;
    window_t   window;
    logic      win_valid;
    pixel_t    median;
    logic      median_valid;

    median_regs u_regs (
        .CLK(CLK), .RST(RST), .ena_i(ena_i), .wea_i(wea_i), .addr_i(addr_i),
        .data_i(data_i), .done_i(done), .res_rdata_i(res_rdata), .data_o(data_o),
        .start_o(start), .width_o(width), .height_o(height), .host_we_o(host_we),
        .host_re_o(host_re), .host_addr_o(host_addr), .host_wdata_o(host_wdata)
    );

    ram_arbiter u_arbiter (
        .busy_i(busy), .host_we_i(host_we), .host_re_i(host_re),
        .host_addr_i(host_addr), .host_wdata_i(host_wdata),
        .eng_src_re_i(eng_src_re), .eng_res_we_i(eng_res_we),
        .eng_addr_i(eng_addr), .eng_wdata_i(eng_wdata),
        .src_en_o(src_en), .src_we_o(src_we), .src_addr_o(src_addr),
        .src_wdata_o(src_wdata), .res_en_o(res_en), .res_we_o(res_we),
        .res_addr_o(res_addr), .res_wdata_o(res_wdata)
    );

    // source frame
    frame_ram u_src_ram (
        .CLK(CLK), .en_i(src_en), .we_i(src_we), .addr_i(src_addr),
        .wdata_i(src_wdata), .rdata_o(src_rdata)
    );

    // filtered frame
    frame_ram u_res_ram (
        .CLK(CLK), .en_i(res_en), .we_i(res_we), .addr_i(res_addr),
        .wdata_i(res_wdata), .rdata_o(res_rdata)
    );

    filter_engine u_engine (
        .CLK(CLK), .RST(RST), .start_i(start), .width_i(width), .height_i(height),
        .src_rdata_i(src_rdata), .median_i(median), .median_valid_i(median_valid),
        .busy_o(busy), .done_o(done), .eng_src_re_o(eng_src_re),
        .eng_res_we_o(eng_res_we), .eng_addr_o(eng_addr), .eng_wdata_o(eng_wdata),
        .window_o(window), .win_valid_o(win_valid)
    );

    median_sort u_sort (
        .CLK(CLK), .RST(RST), .window_i(window), .valid_i(win_valid),
        .median_o(median), .valid_o(median_valid)
    );

endmodule

// File: bench/median_filter_assertions.sv
/* concurrent checks on engine and sorter nets, bound into the filter top */
`timescale 1ns/1ns
`include "median_settings.svh"

module median_filter_assertions (
    input logic CLK,
    input logic RST,
    input logic busy_i,
    input logic done_i,
    input logic res_we_i,
    input logic win_valid_i,
    input logic median_valid_i
);
    // medians only arrive during a sweep, so every result gets written
    res_we_busy: assert property (@(posedge CLK) disable iff (!RST) median_valid_i |-> busy_i)
        else $error("median arrived while the engine is not running");

    // done follows the final result write
    done_not_busy: assert property (@(posedge CLK) disable iff (!RST)
        $rose(done_i) |-> $past(busy_i) && $past(res_we_i))
        else $error("engine reports done without finishing a sweep");

    // fixed network depth
    sort_latency: assert property (@(posedge CLK) disable iff (!RST)
        median_valid_i == $past(win_valid_i, `SORT_LAT))
        else $error("median valid does not follow window valid by the sort latency");

endmodule

bind median_filter_top median_filter_assertions u_assertions (
    .CLK(CLK), .RST(RST), .busy_i(busy), .done_i(done), .res_we_i(eng_res_we),
    .win_valid_i(win_valid), .median_valid_i(median_valid)
);

// File: bench/median_filter_tb.sv
/* testbench for the median filter top with host tasks, reference median model,
   read compare process and watchdog */
`timescale 1ns/1ns
`include "median_settings.svh"

module median_filter_tb
    import median_pkg::*;
();
    localparam int  POLL_MAX    = 2000;
    // six frames of at most 256 pixels at 20 cycles each
    localparam time WATCHDOG_NS = 6 * 256 * 20 * 40;

    logic       CLK;
    logic       RST;
    logic       ena;
    logic       wea;
    host_addr_t addr;
    host_data_t wdata;
    host_data_t rdata;
    logic       rd_pend;

    // copy of the source frame as the host loaded it
    pixel_t     img [256];
    host_data_t exp_q [$];
    string      name_q [$];
    bit         chk_q [$];

    median_filter_top UUT (
        .CLK(CLK), .RST(RST), .ena_i(ena), .wea_i(wea), .addr_i(addr),
        .data_i(wdata), .data_o(rdata)
    );

    always #20 CLK = ~CLK;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input host_data_t exp_v,
                                 input host_data_t act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp_v, act_v);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    function automatic host_addr_t reg_addr(input reg_sel_t sel);
        return {sel, ram_addr_t'(0)};
    endfunction

    function automatic host_addr_t pix_addr(input int a);
        return {SEL_PIXEL, ram_addr_t'(a)};
    endfunction

    // zero padded 3x3 neighbourhood, fifth of nine after sorting
    function automatic int ref_median(input pixel_t im [256], input int w, input int h,
                                      input int r, input int c);
        int v [9];
        int k;
        int t;
        k = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                if (r + dy >= 0 && r + dy < h && c + dx >= 0 && c + dx < w) begin
                    v[k] = im[(r + dy) * w + c + dx];
                end
                else begin
                    v[k] = 0;
                end
                k++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8 - i; j++) begin
                if (v[j] > v[j + 1]) begin
                    t        = v[j];
                    v[j]     = v[j + 1];
                    v[j + 1] = t;
                end
            end
        end
        return v[4];
    endfunction

    task automatic host_write(input host_addr_t a, input host_data_t d);
        @(negedge CLK);
        ena   = 1'b1;
        wea   = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        ena = 1'b0;
        wea = 1'b0;
    endtask

    task automatic host_read(input host_addr_t a, input host_data_t exp_v, input string name,
                             input bit chk, output host_data_t val);
        @(negedge CLK);
        ena  = 1'b1;
        wea  = 1'b0;
        addr = a;
        exp_q.push_back(exp_v);
        name_q.push_back(name);
        chk_q.push_back(chk);
        @(negedge CLK);
        ena = 1'b0;
        val = rdata;
    endtask

    task automatic expect_read(input host_addr_t a, input host_data_t exp_v,
                               input string name);
        host_data_t unused;
        host_read(a, exp_v, name, 1'b1, unused);
    endtask

    // data_o is stable at the falling edge after the request
    always @(posedge CLK) begin
        rd_pend <= ena && !wea;
    end

    always @(negedge CLK) begin : compare_reads
        host_data_t exp_v;
        string      name_v;
        bit         chk_v;
        if (rd_pend) begin
            exp_v  = exp_q.pop_front();
            name_v = name_q.pop_front();
            chk_v  = chk_q.pop_front();
            if (chk_v) begin
                compare_value(name_v, exp_v, rdata);
            end
        end
    end

    task automatic load_image(input int w, input int h, input bit flat);
        for (int i = 0; i < w * h; i++) begin
            img[i] = flat ? pixel_t'(255) : pixel_t'($urandom % 256);
            host_write(pix_addr(i), img[i]);
        end
    endtask

    task automatic start_frame(input int w, input int h);
        host_write(reg_addr(SEL_WIDTH), w);
        host_write(reg_addr(SEL_HEIGHT), h);
        host_write(reg_addr(SEL_CTRL), 1);
    endtask

    task automatic wait_done();
        host_data_t s;
        int         n;
        s = '0;
        n = 0;
        while (!s[0] && n < POLL_MAX) begin
            host_read(reg_addr(SEL_CTRL), '0, "status poll", 1'b0, s);
            n++;
        end
        if (!s[0]) begin
            fail_run("the filter never finished the frame");
        end
    endtask

    task automatic check_frame(input string name, input int w, input int h);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                expect_read(pix_addr(r * w + c), ref_median(img, w, h, r, c),
                            $sformatf("%s r%0d c%0d", name, r, c));
            end
        end
    endtask

    // flat frame: corners see five zeros, every other pixel at most three
    task automatic check_flat(input string name, input int w, input int h);
        bit corner;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                corner = (r == 0 || r == h - 1) && (c == 0 || c == w - 1);
                expect_read(pix_addr(r * w + c), corner ? 0 : 255,
                            $sformatf("%s r%0d c%0d", name, r, c));
            end
        end
    endtask

    task automatic run_frame(input string name, input int w, input int h, input bit flat);
        load_image(w, h, flat);
        start_frame(w, h);
        wait_done();
        if (flat) begin
            check_flat(name, w, h);
        end
        else begin
            check_frame(name, w, h);
        end
        host_write(reg_addr(SEL_CTRL), 0);
    endtask

    initial begin
        int w;
        int h;
        void'($urandom(5110));
        CLK   = 1'b0;
        RST   = 1'b0;
        ena   = 1'b0;
        wea   = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b1;

        expect_read(reg_addr(SEL_CTRL), 0, "reset status");
        expect_read(reg_addr(SEL_WIDTH), 0, "reset width");
        expect_read(reg_addr(SEL_HEIGHT), 0, "reset height");
        expect_read(pix_addr($urandom % 256), 0, "reset pixel");

        w = $urandom % 32;
        h = $urandom % 32;
        host_write(reg_addr(SEL_WIDTH), w);
        host_write(reg_addr(SEL_HEIGHT), h);
        expect_read(reg_addr(SEL_WIDTH), w, "width readback");
        expect_read(reg_addr(SEL_HEIGHT), h, "height readback");
        run_frame("random 8x8", 8, 8, 1'b0);

        run_frame("flat 5x4", 5, 4, 1'b1);
        run_frame("wide 16x3", 16, 3, 1'b0);
        run_frame("single 1x1", 1, 1, 1'b0);

        // pixel writes during the sweep must not reach the source frame
        load_image(6, 6, 1'b0);
        start_frame(6, 6);
        expect_read(reg_addr(SEL_CTRL), 0, "status while running");
        for (int i = 0; i < 36; i++) begin
            host_write(pix_addr(i), $urandom % 256);
        end
        wait_done();
        check_frame("busy writes 6x6", 6, 6);

        host_write(reg_addr(SEL_CTRL), 0);
        expect_read(reg_addr(SEL_CTRL), 0, "status after stop");
        // interior pixel at row 1, column 1 of the 6x6 result
        expect_read(pix_addr(7), 0, "pixel after stop");
        run_frame("restart 7x5", 7, 5, 1'b0);

        repeat (2) @(posedge CLK);
        if (exp_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end
        else begin
            fail_run("some host reads were never compared");
        end
    end

    initial begin
        #WATCHDOG_NS;
        fail_run("watchdog expired before the tests completed");
    end

endmodule

// File: vlog.f
+incdir+logic
logic/median_pkg.sv
logic/frame_ram.sv
logic/median_regs.sv
logic/ram_arbiter.sv
logic/filter_engine.sv
logic/median_sort.sv
logic/median_filter_top.sv
bench/median_filter_assertions.sv
bench/median_filter_tb.sv
